// File: project.f
design/icache_pkg.sv
design/fetch_request_stage.sv
design/icache_lookup.sv
design/line_refill.sv
design/icache_fetch_top.sv
tests/tb_icache_fetch.sv

// File: Bender.yml
package:
  name: icache_fetch

sources:
  # package first, then the pipeline stages and the top level
  - design/icache_pkg.sv
  - design/fetch_request_stage.sv
  - design/icache_lookup.sv
  - design/line_refill.sv
  - design/icache_fetch_top.sv
  - target: test
    files:
      - tests/tb_icache_fetch.sv

// File: tests/tb_icache_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache_fetch;
    import icache_pkg::*;

    localparam int num_tests       = 6;
    localparam int random_reads    = 60;
    localparam int watchdog_cycles = num_tests * 200 + random_reads * 40;
    localparam logic [word_width-1:0] data_key = 16'ha5c3;

    typedef struct packed {
        logic                  hit;
        logic [word_width-1:0] data;
        logic [word_width-1:0] address;
    } expect_t;

    logic clk;
    logic reset_n;
    logic read;
    logic [word_width-1:0] address;
    logic ready;
    fetch_resp_t resp;
    logic mem_read;
    logic [word_width-1:0] mem_address;
    cache_line_t mem_line;
    logic mem_valid;

    // reference cache state
    logic [num_sets-1:0]  ref_valid;
    logic [tag_width-1:0] ref_tag [num_sets];
    expect_t expect_q [$];
    expect_t seen;
    int resp_cycles [$];

    int cycle = 0;
    int error_count = 0;
    int check_count = 0;
    int predicted_misses = 0;
    int mem_reads = 0;
    int mem_latency = 1;
    int active_latency = 1;
    int mem_count = 0;
    int mem_valid_cycle = 0;
    int last_issue_cycle = 0;
    int ready_waits = 0;
    int errors_start;
    int misses_start;
    int reads_start;
    logic [word_width-1:0] last_mem_address;
    logic [31:0] rng_state = 32'hef10_45ec;
    string test_name = "reset";

    icache_fetch_top u_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .read        (read),
        .address     (address),
        .ready       (ready),
        .resp        (resp),
        .mem_read    (mem_read),
        .mem_address (mem_address),
        .mem_line    (mem_line),
        .mem_valid   (mem_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // every word in memory is its own address scrambled by a fixed key
    function automatic logic [word_width-1:0] expected_word(input logic [word_width-1:0] addr);
        return addr ^ data_key;
    endfunction

    // memory model answers mem_read after mem_latency falling edges
    always @(negedge clk) begin
        if (reset_n) begin
            mem_valid = 1'b0;
            mem_count = 0;
        end else if (mem_valid) begin
            mem_valid = 1'b0;
        end else if (mem_read) begin
            if (mem_count == 0) begin
                mem_reads++;
                last_mem_address = mem_address;
                active_latency   = mem_latency;
            end
            mem_count++;
            if (mem_count >= active_latency) begin
                mem_line.word0  = expected_word({mem_address[word_width-1:2], 2'd0});
                mem_line.word1  = expected_word({mem_address[word_width-1:2], 2'd1});
                mem_line.word2  = expected_word({mem_address[word_width-1:2], 2'd2});
                mem_line.word3  = expected_word({mem_address[word_width-1:2], 2'd3});
                mem_valid       = 1'b1;
                mem_valid_cycle = cycle;
                mem_count       = 0;
            end
        end
    end

    // responses come back in issue order so the oldest expectation is compared
    always @(negedge clk) begin
        if (!reset_n && resp.valid) begin
            resp_cycles.push_back(cycle);
            if (expect_q.size() == 0) begin
                $display("test %s: a response arrived with no read outstanding", test_name);
                error_count++;
            end else begin
                seen = expect_q.pop_front();
                check_value($sformatf("hit flag at %h", seen.address), seen.hit, resp.hit);
                check_value($sformatf("data at %h", seen.address), seen.data, resp.data);
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("Error: test %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic predict_read(input logic [word_width-1:0] addr, output expect_t exp);
        logic [index_width-1:0] index;
        logic [tag_width-1:0]   tag;
        index       = addr[offset_width +: index_width];
        tag         = addr[word_width-1 -: tag_width];
        exp.hit     = ref_valid[index] && (ref_tag[index] == tag);
        exp.data    = expected_word(addr);
        exp.address = addr;
        if (!exp.hit) begin
            ref_valid[index] = 1'b1;
            ref_tag[index]   = tag;
            predicted_misses++;
        end
    endtask

    // called on a falling edge and leaves read high for one cycle
    task automatic issue_read(input logic [word_width-1:0] addr);
        expect_t exp;
        while (!ready) begin
            read = 1'b0;
            ready_waits++;
            @(negedge clk);
        end
        read    = 1'b1;
        address = addr;
        predict_read(addr, exp);
        expect_q.push_back(exp);
        last_issue_cycle = cycle;
        @(negedge clk);
    endtask

    task automatic wait_responses(input int limit);
        int waited;
        read   = 1'b0;
        waited = 0;
        while (expect_q.size() != 0 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("test %s: %0d read(s) never got a response", test_name, expect_q.size());
            error_count++;
            expect_q.delete();
        end
    endtask

    task automatic apply_reset();
        reset_n = 1'b1;
        read    = 1'b0;
        repeat (10) @(negedge clk);
        reset_n   = 1'b0;
        ref_valid = '0;
        expect_q.delete();
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        errors_start = error_count;
        misses_start = predicted_misses;
        reads_start  = mem_reads;
        resp_cycles.delete();
        rng_state   = xorshift32(rng_state);
        mem_latency = 1 + rng_state % 6;
    endtask

    task automatic finish_test();
        check_value("memory reads", predicted_misses - misses_start, mem_reads - reads_start);
        $display("test %s finished with %0d error(s)", test_name, error_count - errors_start);
    endtask

    task automatic test_cold_miss();
        int issued;
        start_test("cold_miss");
        issue_read(16'h0a36);
        wait_responses(100);
        if (mem_reads == reads_start) begin
            $display("test %s: the miss never raised mem_read", test_name);
            error_count++;
        end else begin
            check_value("memory address", 16'h0a34, last_mem_address);
        end
        if (resp_cycles.size() > 0) begin
            check_value("miss response delay", 2, resp_cycles[0] - mem_valid_cycle);
        end
        resp_cycles.delete();
        issue_read(16'h0a36);
        issued = last_issue_cycle;
        wait_responses(20);
        if (resp_cycles.size() > 0) begin
            check_value("hit response delay", 2, resp_cycles[0] - issued);
        end
        finish_test();
    endtask

    task automatic test_line_fill();
        start_test("line_fill");
        issue_read(16'h2c41);
        wait_responses(100);
        for (int i = 0; i < line_words; i++) begin
            issue_read(16'h2c40 + i);
        end
        wait_responses(100);
        finish_test();
    endtask

    task automatic test_conflict();
        start_test("conflict");
        issue_read(16'h7310);
        wait_responses(100);
        // same set with a different tag
        issue_read(16'h9b12);
        wait_responses(100);
        issue_read(16'h7311);
        wait_responses(100);
        finish_test();
    endtask

    task automatic test_stream_stall();
        start_test("stream_stall");
        issue_read(16'h5a28);
        wait_responses(100);
        resp_cycles.delete();
        for (int i = 0; i < line_words; i++) begin
            issue_read(16'h5a28 + i);
        end
        wait_responses(100);
        check_value("streamed responses", 4, resp_cycles.size());
        if (resp_cycles.size() == 4) begin
            check_value("streamed response span", 3, resp_cycles[3] - resp_cycles[0]);
        end
        // a miss followed by reads that pile up behind it
        // the held read targets the line being filled
        ready_waits = 0;
        issue_read(16'h6e3c);
        issue_read(16'h6e3d);
        issue_read(16'h5a29);
        issue_read(16'h6e3e);
        wait_responses(100);
        check_value("ready dropped behind the miss", 1, ready_waits > 0);
        finish_test();
    endtask

    task automatic test_reset();
        int waited;
        start_test("reset");
        issue_read(16'h1104);
        issue_read(16'h3308);
        wait_responses(100);
        mem_latency = 4;
        // a miss with a read held behind it, so ready is low going into reset
        issue_read(16'h4410);
        issue_read(16'h4411);
        read   = 1'b0;
        waited = 0;
        while (!mem_read && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!mem_read) begin
            $display("test %s: the miss before reset never raised mem_read", test_name);
            error_count++;
        end
        @(negedge clk);
        apply_reset();
        check_value("mem_read after reset", 0, mem_read);
        check_value("resp.valid after reset", 0, resp.valid);
        check_value("ready after reset", 1, ready);
        issue_read(16'h1104);
        issue_read(16'h3308);
        wait_responses(100);
        finish_test();
    endtask

    task automatic test_random();
        logic [tag_width-1:0]  tags [3] = '{12'h0a1, 12'h3c7, 12'h5e2};
        logic [word_width-1:0] addr;
        start_test("random");
        for (int i = 0; i < random_reads; i++) begin
            rng_state   = xorshift32(rng_state);
            mem_latency = 1 + int'(rng_state[10:8]) % 6;
            addr        = {tags[rng_state[17:16] % 3], rng_state[3:0]};
            issue_read(addr);
            // sometimes let the pipeline drain instead of streaming
            if (rng_state[24]) begin
                wait_responses(100);
            end
        end
        wait_responses(100);
        finish_test();
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b1;
        read      = 1'b0;
        address   = '0;
        mem_valid = 1'b0;
        mem_line  = '0;
        apply_reset();
        test_cold_miss();
        test_line_fill();
        test_conflict();
        test_stream_stall();
        test_reset();
        test_random();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/icache_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_top (
    input  logic                              clk,
    input  logic                              reset_n,
    // CPU side
    input  logic                              read,
    input  logic [icache_pkg::word_width-1:0] address,
    output logic                              ready,
    output icache_pkg::fetch_resp_t           resp,
    // memory side
    output logic                              mem_read,
    output logic [icache_pkg::word_width-1:0] mem_address,
    input  icache_pkg::cache_line_t           mem_line,
    input  logic                              mem_valid
);
    import icache_pkg::*;

    fetch_req_t             req;
    logic                   stall;
    refill_req_t            refill_req;
    logic                   fill_valid;
    logic [index_width-1:0] fill_index;
    cache_line_t            fill_line;

    fetch_request_stage u_request (
        .clk     (clk),
        .reset_n (reset_n),
        .read    (read),
        .address (address),
        .stall   (stall),
        .req     (req),
        .ready   (ready)
    );

    icache_lookup u_lookup (
        .clk        (clk),
        .reset_n    (reset_n),
        .req        (req),
        .fill_valid (fill_valid),
        .fill_index (fill_index),
        .fill_line  (fill_line),
        .stall      (stall),
        .refill_req (refill_req),
        .resp       (resp)
    );

    // a single refill at a time, lookup stalls until it finishes
    line_refill u_refill (
        .clk         (clk),
        .reset_n     (reset_n),
        .refill_req  (refill_req),
        .mem_line    (mem_line),
        .mem_valid   (mem_valid),
        .mem_read    (mem_read),
        .mem_address (mem_address),
        .fill_valid  (fill_valid),
        .fill_index  (fill_index),
        .fill_line   (fill_line)
    );

endmodule

`default_nettype wire

// File: design/line_refill.sv
`timescale 1ns/1ps
`default_nettype none

module line_refill (
    input  logic                               clk,
    input  logic                               reset_n,
    input  icache_pkg::refill_req_t            refill_req,
    input  icache_pkg::cache_line_t            mem_line,
    input  logic                               mem_valid,
    output logic                               mem_read,
    output logic [icache_pkg::word_width-1:0]  mem_address,
    output logic                               fill_valid,
    output logic [icache_pkg::index_width-1:0] fill_index,
    output icache_pkg::cache_line_t            fill_line
);
    import icache_pkg::*;

    refill_state_t state;
    refill_state_t state_next;

    logic [tag_width-1:0]   line_tag;
    logic [index_width-1:0] line_index;
    cache_line_t            line_data;

    always_comb begin
        state_next = state;
        case (state)
            refill_idle: begin
                if (refill_req.valid) begin
                    state_next = refill_wait;
                end
            end
            refill_wait: begin
                // memory may take any number of cycles
                if (mem_valid) begin
                    state_next = refill_deliver;
                end
            end
            refill_deliver: begin
                state_next = refill_idle;
            end
            default: begin
                state_next = refill_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state <= refill_idle;
        end else begin
            state <= state_next;
        end
    end

    // request fields and the returned line
    always_ff @(posedge clk) begin
        if (state == refill_idle && refill_req.valid) begin
            line_tag   <= refill_req.tag;
            line_index <= refill_req.index;
        end
        if (state == refill_wait && mem_valid) begin
            line_data <= mem_line;
        end
    end

    // memory side, mem_read drops once mem_valid has been seen
    assign mem_read    = (state == refill_wait);
    assign mem_address = {line_tag, line_index, {offset_width{1'b0}}};

    // lookup side, one pulse per refill
    assign fill_valid = (state == refill_deliver);
    assign fill_index = line_index;
    assign fill_line  = line_data;

endmodule

`default_nettype wire

// File: design/icache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module icache_lookup (
    input  logic                               clk,
    input  logic                               reset_n,
    input  icache_pkg::fetch_req_t             req,
    input  logic                               fill_valid,
    input  logic [icache_pkg::index_width-1:0] fill_index,
    input  icache_pkg::cache_line_t            fill_line,
    output logic                               stall,
    output icache_pkg::refill_req_t            refill_req,
    output icache_pkg::fetch_resp_t            resp
);
    import icache_pkg::*;

    // per-set storage
    logic [num_sets-1:0]  line_valid;
    logic [tag_width-1:0] tag_array [num_sets];
    cache_line_t          data_array [num_sets];

    logic lookup_hit;
    logic take_req;
    logic take_fill;

    // miss capture, replayed when the line comes back
    logic [tag_width-1:0]    miss_tag;
    logic [index_width-1:0]  miss_index;
    logic [offset_width-1:0] miss_offset;
    logic                    refill_valid;

    // response register
    logic                  resp_valid;
    logic                  resp_hit;
    logic [word_width-1:0] resp_data;

    function automatic logic [word_width-1:0] select_word(
        input cache_line_t             line,
        input logic [offset_width-1:0] offset
    );
        logic [word_width-1:0] word;
        case (offset)
            2'd0:    word = line.word0;
            2'd1:    word = line.word1;
            2'd2:    word = line.word2;
            default: word = line.word3;
        endcase
        return word;
    endfunction

    // while a miss is outstanding the request stage holds, so req is ignored
    assign take_req  = req.valid && !stall;
    assign take_fill = fill_valid && stall;

    assign lookup_hit = line_valid[req.index] && (tag_array[req.index] == req.tag);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            line_valid   <= '0;
            stall        <= 1'b0;
            refill_valid <= 1'b0;
            resp_valid   <= 1'b0;
            resp_hit     <= 1'b0;
        end else begin
            resp_valid   <= 1'b0;
            refill_valid <= 1'b0;
            if (take_fill) begin
                line_valid[fill_index] <= 1'b1;
                stall                  <= 1'b0;
                resp_valid             <= 1'b1;
                resp_hit               <= 1'b0;
            end else if (take_req) begin
                resp_hit <= lookup_hit;
                if (lookup_hit) begin
                    resp_valid <= 1'b1;
                end else begin
                    stall        <= 1'b1;
                    refill_valid <= 1'b1;
                end
            end
        end
    end

    // arrays and payload
    always_ff @(posedge clk) begin
        if (take_fill) begin
            tag_array[fill_index]  <= miss_tag;
            data_array[fill_index] <= fill_line;
            // the waiting read gets its word straight from the returned line
            resp_data <= select_word(fill_line, miss_offset);
        end else if (take_req) begin
            if (lookup_hit) begin
                resp_data <= select_word(data_array[req.index], req.offset);
            end else begin
                miss_tag    <= req.tag;
                miss_index  <= req.index;
                miss_offset <= req.offset;
            end
        end
    end

    always_comb begin
        refill_req       = '0;
        refill_req.valid = refill_valid;
        refill_req.tag   = miss_tag;
        refill_req.index = miss_index;
    end

    always_comb begin
        resp       = '0;
        resp.valid = resp_valid;
        resp.hit   = resp_hit;
        resp.data  = resp_data;
    end

endmodule

`default_nettype wire

// File: design/fetch_request_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_request_stage (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             read,
    input  logic [icache_pkg::word_width-1:0] address,
    input  logic                             stall,
    output icache_pkg::fetch_req_t           req,
    output logic                             ready
);
    import icache_pkg::*;

    // field boundaries inside the CPU address
    localparam int index_lsb = offset_width;
    localparam int tag_lsb   = offset_width + index_width;

    logic                    req_valid;
    logic [tag_width-1:0]    req_tag;
    logic [index_width-1:0]  req_index;
    logic [offset_width-1:0] req_offset;
    logic                    load;

    // an empty slot can always take a read, even while lookup is busy
    assign load = !stall || !req_valid;

    // only a held read blocks the CPU
    assign ready = !(stall && req_valid);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            req_valid <= 1'b0;
        end else if (load) begin
            req_valid <= read;
        end
    end

    // address fields only change when a new read is taken
    always_ff @(posedge clk) begin
        if (load && read) begin
            req_tag    <= address[word_width-1:tag_lsb];
            req_index  <= address[tag_lsb-1:index_lsb];
            req_offset <= address[offset_width-1:0];
        end
    end

    always_comb begin
        req        = '0;
        req.valid  = req_valid;
        req.tag    = req_tag;
        req.index  = req_index;
        req.offset = req_offset;
    end

endmodule

`default_nettype wire

// File: design/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry, matching a 16-bit fetch path
    localparam int word_width   = 16;
    localparam int tag_width    = 12;
    localparam int num_sets     = 4;
    localparam int line_words   = 4;
    localparam int index_width  = 2;
    localparam int offset_width = 2;

    // decoded CPU read as it leaves the request stage
    typedef struct packed {
        logic                    valid;
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;
    } fetch_req_t;

    // one full line, word0 sits at the lowest address
    typedef struct packed {
        logic [word_width-1:0] word3;
        logic [word_width-1:0] word2;
        logic [word_width-1:0] word1;
        logic [word_width-1:0] word0;
    } cache_line_t;

    // response back to the CPU, valid is a single-cycle pulse
    typedef struct packed {
        logic                  valid;
        logic                  hit;
        logic [word_width-1:0] data;
    } fetch_resp_t;

    // line request from lookup to the refill engine
    typedef struct packed {
        logic                   valid;
        logic [tag_width-1:0]   tag;
        logic [index_width-1:0] index;
    } refill_req_t;

    typedef enum logic [1:0] {
        refill_idle    = 2'd0,
        refill_wait    = 2'd1,
        refill_deliver = 2'd2
    } refill_state_t;

endpackage

`default_nettype wire
